// ==== common/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

  // one machine word for data and addresses and instructions
  typedef logic [31:0] word_t;

  // architectural register index
  // with 16 registers only the low 4 bits select an entry
  typedef logic [4:0] reg_idx_t;

  // alu operation code
  typedef logic [3:0] alu_op_t;

  // codes follow the R type layout {funct7[5], funct3}
  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  // unused R type slots carry the less-or-equal compares for bge and bgeu
  localparam alu_op_t ALU_SLE  = 4'b1010;
  localparam alu_op_t ALU_SLEU = 4'b1011;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  // operand 1 source
  // RS2 only appears on the swapped bge and bgeu compares
  typedef enum logic [1:0] {
    OP1_ZERO = 2'd0,
    OP1_PC   = 2'd1,
    OP1_RS1  = 2'd2,
    OP1_RS2  = 2'd3
  } op1_sel_t;

  // operand 2 source
  typedef enum logic [1:0] {
    OP2_IMM  = 2'd0,
    OP2_FOUR = 2'd1,
    OP2_RS2  = 2'd2,
    OP2_RS1  = 2'd3
  } op2_sel_t;

  // controls produced by the instruction decoder
  typedef struct packed {
    alu_op_t  alu_op;
    op1_sel_t op1_sel;
    op2_sel_t op2_sel;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_rs1;
    logic     use_rs2;
    reg_idx_t rd;
    logic     rd_wen;
    logic     mem_ren;
    logic     mem_wen;
    logic     is_jump;
    logic     is_branch;
    logic     is_system;
    logic     csr_wen;
    logic     ebreak;
    logic     illegal;
  } decode_t;

  // one bypass source from execute or writeback
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } fwd_t;

  // fetched instruction with its pc
  typedef struct packed {
    word_t pc;
    word_t inst;
  } fetch_t;

  // payload handed to execute
  typedef struct packed {
    word_t    pc;
    word_t    inst;
    alu_op_t  alu_op;
    word_t    op1;
    word_t    op2;
    word_t    imm;
    reg_idx_t rd;
    logic     rd_wen;
    logic     mem_ren;
    logic     mem_wen;
    word_t    mem_addr;
    word_t    jump_base;
    logic     is_jump;
    logic     is_branch;
    logic     is_system;
    logic     csr_wen;
    logic     ebreak;
    logic     illegal;
  } issue_t;

endpackage

`default_nettype wire

// ==== idu/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
  parameter int NUM_REGS = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     fetch_valid_i,
  input  rv_decode_pkg::fetch_t    fetch_i,
  output logic                     fetch_ready_o,
  output logic                     issue_valid_o,
  output rv_decode_pkg::issue_t    issue_o,
  input  logic                     issue_ready_i,
  input  rv_decode_pkg::fwd_t      exu_fwd_i,
  input  rv_decode_pkg::fwd_t      wb_fwd_i,
  output rv_decode_pkg::reg_idx_t  rf_raddr1_o,
  output rv_decode_pkg::reg_idx_t  rf_raddr2_o,
  input  rv_decode_pkg::word_t     rf_rdata1_i,
  input  rv_decode_pkg::word_t     rf_rdata2_i
);

  // the one instruction in flight
  rv_decode_pkg::fetch_t  held_q;
  logic                   held_valid_q;

  // operands frozen while execute back-pressures
  logic                   park_q;
  rv_decode_pkg::word_t   rs1_q;
  rv_decode_pkg::word_t   rs2_q;

  rv_decode_pkg::decode_t dec;
  rv_decode_pkg::word_t   rs1_val;
  rv_decode_pkg::word_t   rs2_val;
  rv_decode_pkg::word_t   rs1;
  rv_decode_pkg::word_t   rs2;
  logic                   rs1_pending;
  logic                   rs2_pending;
  logic                   hazard;
  logic                   issue_fire;

  inst_decoder u_decoder (
    .inst_i (held_q.inst),
    .dec_o  (dec)
  );

  operand_unit #(
    .NUM_REGS (NUM_REGS)
  ) u_operands (
    .clk            (clk),
    .rst            (rst),
    .inst_i         (held_q.inst),
    .rf_rdata1_i    (rf_rdata1_i),
    .rf_rdata2_i    (rf_rdata2_i),
    .rf_raddr1_o    (rf_raddr1_o),
    .rf_raddr2_o    (rf_raddr2_o),
    .exu_fwd_i      (exu_fwd_i),
    .wb_fwd_i       (wb_fwd_i),
    .issue_fire_i   (issue_fire),
    .issue_rd_i     (dec.rd),
    .issue_rd_wen_i (dec.rd_wen),
    .rs1_val_o      (rs1_val),
    .rs2_val_o      (rs2_val),
    .rs1_pending_o  (rs1_pending),
    .rs2_pending_o  (rs2_pending)
  );

  // only sources the instruction really reads can stall it
  assign hazard = (dec.use_rs1 && rs1_pending) || (dec.use_rs2 && rs2_pending);

  // once parked the payload no longer depends on the bypass inputs
  assign issue_valid_o = held_valid_q && (park_q || !hazard);
  assign issue_fire    = issue_valid_o && issue_ready_i;
  assign fetch_ready_o = !held_valid_q || issue_fire;

  assign rs1 = park_q ? rs1_q : rs1_val;
  assign rs2 = park_q ? rs2_q : rs2_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid_q <= 1'b0;
      park_q       <= 1'b0;
    end else begin
      if (fetch_ready_o) begin
        held_valid_q <= fetch_valid_i;
      end
      if (issue_fire) begin
        park_q <= 1'b0;
      end else if (issue_valid_o) begin
        park_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid_i && fetch_ready_o) begin
      held_q <= fetch_i;
    end
    // keeps the values seen when valid first rose
    if (!park_q) begin
      rs1_q <= rs1_val;
      rs2_q <= rs2_val;
    end
  end

  always_comb begin
    issue_o.pc     = held_q.pc;
    issue_o.inst   = held_q.inst;
    issue_o.alu_op = dec.alu_op;
    issue_o.imm    = dec.imm;

    case (dec.op1_sel)
      rv_decode_pkg::OP1_PC:  issue_o.op1 = held_q.pc;
      rv_decode_pkg::OP1_RS1: issue_o.op1 = rs1;
      rv_decode_pkg::OP1_RS2: issue_o.op1 = rs2;
      default:                issue_o.op1 = '0;
    endcase

    case (dec.op2_sel)
      rv_decode_pkg::OP2_FOUR: issue_o.op2 = 32'd4;
      rv_decode_pkg::OP2_RS2:  issue_o.op2 = rs2;
      rv_decode_pkg::OP2_RS1:  issue_o.op2 = rs1;
      default:                 issue_o.op2 = dec.imm;
    endcase

    issue_o.rd       = dec.rd;
    issue_o.rd_wen   = dec.rd_wen;
    issue_o.mem_ren  = dec.mem_ren;
    issue_o.mem_wen  = dec.mem_wen;
    issue_o.mem_addr = rs1 + dec.imm;
    // jalr is the only jump that reads rs1
    issue_o.jump_base = (dec.is_jump && dec.use_rs1) ? rs1 : held_q.pc;

    issue_o.is_jump   = dec.is_jump;
    issue_o.is_branch = dec.is_branch;
    issue_o.is_system = dec.is_system;
    issue_o.csr_wen   = dec.csr_wen;
    issue_o.ebreak    = dec.ebreak;
    issue_o.illegal   = dec.illegal;
  end

endmodule

`default_nettype wire

// ==== idu/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  rv_decode_pkg::word_t   inst_i,
  output rv_decode_pkg::decode_t dec_o
);

  rv_decode_pkg::opcode_t opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;

  // immediates for each instruction format
  rv_decode_pkg::word_t imm_i;
  rv_decode_pkg::word_t imm_s;
  rv_decode_pkg::word_t imm_b;
  rv_decode_pkg::word_t imm_u;
  rv_decode_pkg::word_t imm_j;

  assign opcode = rv_decode_pkg::opcode_t'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  // all formats sign extend from bit 31
  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    // everything off unless the opcode turns it on
    dec_o         = '0;
    dec_o.alu_op  = rv_decode_pkg::ALU_ADD;
    dec_o.op1_sel = rv_decode_pkg::OP1_ZERO;
    dec_o.op2_sel = rv_decode_pkg::OP2_IMM;
    // register fields sit in the same place in every format
    dec_o.rs1     = inst_i[19:15];
    dec_o.rs2     = inst_i[24:20];
    dec_o.rd      = inst_i[11:7];

    case (opcode)
      rv_decode_pkg::OP_LUI: begin
        // rd = 0 + imm
        dec_o.imm    = imm_u;
        dec_o.rd_wen = 1'b1;
      end
      rv_decode_pkg::OP_AUIPC: begin
        dec_o.op1_sel = rv_decode_pkg::OP1_PC;
        dec_o.imm     = imm_u;
        dec_o.rd_wen  = 1'b1;
      end
      rv_decode_pkg::OP_JAL: begin
        // alu forms the link address pc + 4
        dec_o.op1_sel = rv_decode_pkg::OP1_PC;
        dec_o.op2_sel = rv_decode_pkg::OP2_FOUR;
        dec_o.imm     = imm_j;
        dec_o.rd_wen  = 1'b1;
        dec_o.is_jump = 1'b1;
      end
      rv_decode_pkg::OP_JALR: begin
        dec_o.op1_sel = rv_decode_pkg::OP1_PC;
        dec_o.op2_sel = rv_decode_pkg::OP2_FOUR;
        dec_o.imm     = imm_i;
        dec_o.use_rs1 = 1'b1;
        dec_o.rd_wen  = 1'b1;
        dec_o.is_jump = 1'b1;
      end
      rv_decode_pkg::OP_BRANCH: begin
        dec_o.op1_sel   = rv_decode_pkg::OP1_RS1;
        dec_o.op2_sel   = rv_decode_pkg::OP2_RS2;
        dec_o.imm       = imm_b;
        dec_o.use_rs1   = 1'b1;
        dec_o.use_rs2   = 1'b1;
        dec_o.is_branch = 1'b1;
        // execute only needs a zero or nonzero result per compare
        case (funct3)
          3'b000: dec_o.alu_op = rv_decode_pkg::ALU_SUB;
          3'b001: dec_o.alu_op = rv_decode_pkg::ALU_XOR;
          3'b100: dec_o.alu_op = rv_decode_pkg::ALU_SLT;
          3'b110: dec_o.alu_op = rv_decode_pkg::ALU_SLTU;
          3'b101: begin
            // bge becomes rs2 <= rs1
            dec_o.alu_op  = rv_decode_pkg::ALU_SLE;
            dec_o.op1_sel = rv_decode_pkg::OP1_RS2;
            dec_o.op2_sel = rv_decode_pkg::OP2_RS1;
          end
          3'b111: begin
            dec_o.alu_op  = rv_decode_pkg::ALU_SLEU;
            dec_o.op1_sel = rv_decode_pkg::OP1_RS2;
            dec_o.op2_sel = rv_decode_pkg::OP2_RS1;
          end
          default: dec_o.illegal = 1'b1;
        endcase
      end
      rv_decode_pkg::OP_LOAD: begin
        // access width stays in funct3 of the issued inst
        dec_o.op1_sel = rv_decode_pkg::OP1_RS1;
        dec_o.imm     = imm_i;
        dec_o.use_rs1 = 1'b1;
        dec_o.rd_wen  = 1'b1;
        dec_o.mem_ren = 1'b1;
      end
      rv_decode_pkg::OP_STORE: begin
        // op2 carries the store data
        dec_o.op1_sel = rv_decode_pkg::OP1_RS1;
        dec_o.op2_sel = rv_decode_pkg::OP2_RS2;
        dec_o.imm     = imm_s;
        dec_o.use_rs1 = 1'b1;
        dec_o.use_rs2 = 1'b1;
        dec_o.mem_wen = 1'b1;
      end
      rv_decode_pkg::OP_IMM: begin
        dec_o.op1_sel = rv_decode_pkg::OP1_RS1;
        dec_o.imm     = imm_i;
        dec_o.use_rs1 = 1'b1;
        dec_o.rd_wen  = 1'b1;
        // only srai uses funct7 since addi has no subtract form
        dec_o.alu_op  = {(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3};
      end
      rv_decode_pkg::OP_REG: begin
        dec_o.op1_sel = rv_decode_pkg::OP1_RS1;
        dec_o.op2_sel = rv_decode_pkg::OP2_RS2;
        dec_o.use_rs1 = 1'b1;
        dec_o.use_rs2 = 1'b1;
        dec_o.rd_wen  = 1'b1;
        dec_o.alu_op  = {funct7[5], funct3};
      end
      rv_decode_pkg::OP_SYSTEM: begin
        // imm holds the csr address or the system function code
        dec_o.is_system = 1'b1;
        dec_o.imm       = imm_i;
        if (funct3 == 3'b000) begin
          dec_o.ebreak = (inst_i[31:20] == 12'h001);
        end else begin
          // csr ops return the old value to rd
          dec_o.csr_wen = 1'b1;
          dec_o.rd_wen  = 1'b1;
          // immediate forms take zimm from the rs1 field of inst
          dec_o.use_rs1 = !funct3[2];
          dec_o.op1_sel = funct3[2] ? rv_decode_pkg::OP1_ZERO : rv_decode_pkg::OP1_RS1;
        end
      end
      default: begin
        // issued as a no-op with every write enable left low
        dec_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== idu/operand_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_unit #(
  parameter int NUM_REGS = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  rv_decode_pkg::word_t     inst_i,
  input  rv_decode_pkg::word_t     rf_rdata1_i,
  input  rv_decode_pkg::word_t     rf_rdata2_i,
  output rv_decode_pkg::reg_idx_t  rf_raddr1_o,
  output rv_decode_pkg::reg_idx_t  rf_raddr2_o,
  input  rv_decode_pkg::fwd_t      exu_fwd_i,
  input  rv_decode_pkg::fwd_t      wb_fwd_i,
  input  logic                     issue_fire_i,
  input  rv_decode_pkg::reg_idx_t  issue_rd_i,
  input  logic                     issue_rd_wen_i,
  output rv_decode_pkg::word_t     rs1_val_o,
  output rv_decode_pkg::word_t     rs2_val_o,
  output logic                     rs1_pending_o,
  output logic                     rs2_pending_o
);

  // only the low index bits take part in any lookup
  localparam int IDX_W = $clog2(NUM_REGS);

  rv_decode_pkg::reg_idx_t rs1;
  rv_decode_pkg::reg_idx_t rs2;

  // one busy bit per register with an outstanding write
  logic [NUM_REGS-1:0] busy_q;
  logic [NUM_REGS-1:0] set_mask;
  logic [NUM_REGS-1:0] clr_mask;

  // a bypass never matches register 0
  function automatic logic fwd_hit(rv_decode_pkg::fwd_t fwd, rv_decode_pkg::reg_idx_t rs);
    return fwd.valid && (fwd.rd[IDX_W-1:0] == rs[IDX_W-1:0]) && (rs[IDX_W-1:0] != '0);
  endfunction

  // execute beats writeback which beats the register file
  function automatic rv_decode_pkg::word_t pick(rv_decode_pkg::reg_idx_t rs,
                                                rv_decode_pkg::word_t rf_data);
    if (fwd_hit(exu_fwd_i, rs)) begin
      return exu_fwd_i.data;
    end
    if (fwd_hit(wb_fwd_i, rs)) begin
      return wb_fwd_i.data;
    end
    return rf_data;
  endfunction

  // busy and not covered by either bypass
  function automatic logic waits(rv_decode_pkg::reg_idx_t rs);
    return busy_q[rs[IDX_W-1:0]] && !fwd_hit(exu_fwd_i, rs) && !fwd_hit(wb_fwd_i, rs);
  endfunction

  // single bit mask for a write to a nonzero register
  function automatic logic [NUM_REGS-1:0] idx_mask(logic en, rv_decode_pkg::reg_idx_t idx);
    logic [NUM_REGS-1:0] mask;
    mask = '0;
    if (en && (idx[IDX_W-1:0] != '0)) begin
      mask[idx[IDX_W-1:0]] = 1'b1;
    end
    return mask;
  endfunction

  assign rs1 = inst_i[19:15];
  assign rs2 = inst_i[24:20];

  assign rf_raddr1_o = rs1;
  assign rf_raddr2_o = rs2;

  // register file already returns zero for register 0
  assign rs1_val_o = pick(rs1, rf_rdata1_i);
  assign rs2_val_o = pick(rs2, rf_rdata2_i);

  assign rs1_pending_o = waits(rs1);
  assign rs2_pending_o = waits(rs2);

  assign set_mask = idx_mask(issue_fire_i && issue_rd_wen_i, issue_rd_i);
  assign clr_mask = idx_mask(wb_fwd_i.valid, wb_fwd_i.rd);

  // set applied after clear so a same edge issue keeps the bit
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~clr_mask) | set_mask;
    end
  end

endmodule

`default_nettype wire

// ==== rv_decode.f ====
common/rv_decode_pkg.sv
idu/inst_decoder.sv
idu/operand_unit.sv
idu/decode_stage.sv
source/reg_file.sv
source/rv_decode_top.sv
test/rv_decode_assertions.sv
test/rv_decode_tb.sv

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int NUM_REGS = 16
) (
  input  logic                    clk,
  input  rv_decode_pkg::reg_idx_t raddr1_i,
  input  rv_decode_pkg::reg_idx_t raddr2_i,
  output rv_decode_pkg::word_t    rdata1_o,
  output rv_decode_pkg::word_t    rdata2_o,
  input  logic                    wen_i,
  input  rv_decode_pkg::reg_idx_t waddr_i,
  input  rv_decode_pkg::word_t    wdata_i
);

  localparam int IDX_W = $clog2(NUM_REGS);

  rv_decode_pkg::word_t regs [NUM_REGS];

  // entry 0 is never written
  always_ff @(posedge clk) begin
    if (wen_i && (waddr_i[IDX_W-1:0] != '0)) begin
      regs[waddr_i[IDX_W-1:0]] <= wdata_i;
    end
  end

  // reads are combinational and register 0 is hardwired to zero
  assign rdata1_o = (raddr1_i[IDX_W-1:0] == '0) ? '0 : regs[raddr1_i[IDX_W-1:0]];
  assign rdata2_o = (raddr2_i[IDX_W-1:0] == '0) ? '0 : regs[raddr2_i[IDX_W-1:0]];

endmodule

`default_nettype wire

// ==== source/rv_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top #(
  // 16 for RV32E and 32 for the full base set
  parameter int NUM_REGS = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_valid_i,
  input  rv_decode_pkg::fetch_t fetch_i,
  output logic                  fetch_ready_o,
  output logic                  issue_valid_o,
  output rv_decode_pkg::issue_t issue_o,
  input  logic                  issue_ready_i,
  input  rv_decode_pkg::fwd_t   exu_fwd_i,
  input  rv_decode_pkg::fwd_t   wb_i
);

  rv_decode_pkg::reg_idx_t rf_raddr1;
  rv_decode_pkg::reg_idx_t rf_raddr2;
  rv_decode_pkg::word_t    rf_rdata1;
  rv_decode_pkg::word_t    rf_rdata2;

  decode_stage #(
    .NUM_REGS (NUM_REGS)
  ) u_stage (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_valid_o (issue_valid_o),
    .issue_o       (issue_o),
    .issue_ready_i (issue_ready_i),
    .exu_fwd_i     (exu_fwd_i),
    .wb_fwd_i      (wb_i),
    .rf_raddr1_o   (rf_raddr1),
    .rf_raddr2_o   (rf_raddr2),
    .rf_rdata1_i   (rf_rdata1),
    .rf_rdata2_i   (rf_rdata2)
  );

  // writeback lands in the array on the same edge it bypasses
  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) u_regs (
    .clk      (clk),
    .raddr1_i (rf_raddr1),
    .raddr2_i (rf_raddr2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .wen_i    (wb_i.valid),
    .waddr_i  (wb_i.rd),
    .wdata_i  (wb_i.data)
  );

endmodule

`default_nettype wire

// ==== test/rv_decode_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic                  issue_valid_i,
  input logic                  issue_ready_i,
  input rv_decode_pkg::issue_t issue_i
);

  // a stalled transfer keeps its payload and stays offered
  property payload_held;
    @(posedge clk) disable iff (rst)
      (issue_valid_i && !issue_ready_i) |=> (issue_valid_i && $stable(issue_i));
  endproperty

  // nothing is offered while in reset or right after it
  property quiet_after_reset;
    @(posedge clk) rst |=> !issue_valid_i;
  endproperty

  assert property (payload_held) else $error("issue payload changed under back-pressure");
  assert property (quiet_after_reset) else $error("issue valid high around reset");

endmodule

bind decode_stage rv_decode_assertions u_assertions (
  .clk           (clk),
  .rst           (rst),
  .issue_valid_i (issue_valid_o),
  .issue_ready_i (issue_ready_i),
  .issue_i       (issue_o)
);

`default_nettype wire

// ==== test/rv_decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_tb;

  localparam int TIMEOUT = 200;

  logic                  clk;
  logic                  rst;
  logic                  fetch_valid_i;
  rv_decode_pkg::fetch_t fetch_i;
  logic                  fetch_ready_o;
  logic                  issue_valid_o;
  rv_decode_pkg::issue_t issue_o;
  logic                  issue_ready_i;
  rv_decode_pkg::fwd_t   exu_fwd_i;
  rv_decode_pkg::fwd_t   wb_i;

  // reference copy of the architectural registers
  rv_decode_pkg::word_t model [16];

  // case table
  // op1 source codes 0 zero 1 pc 2 rs1 3 rs2
  // op2 source codes 0 imm 1 four 2 rs2 3 rs1
  // flags {rd_wen, mem_ren, mem_wen, is_jump, is_branch, is_system, csr_wen, ebreak, illegal}
  string                  row_name [$];
  rv_decode_pkg::word_t   row_inst [$];
  rv_decode_pkg::alu_op_t row_alu [$];
  int                     row_s1 [$];
  int                     row_s2 [$];
  rv_decode_pkg::word_t   row_imm [$];
  logic [8:0]             row_flags [$];
  bit                     row_jb_rs1 [$];

  rv_decode_pkg::issue_t got;
  rv_decode_pkg::issue_t saved;
  rv_decode_pkg::word_t  data;
  int                    waited;

  rv_decode_top #(
    .NUM_REGS (16)
  ) DUT (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_valid_o (issue_valid_o),
    .issue_o       (issue_o),
    .issue_ready_i (issue_ready_i),
    .exu_fwd_i     (exu_fwd_i),
    .wb_i          (wb_i)
  );

  always #4 clk = ~clk;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // RV32 encoders
  function automatic rv_decode_pkg::word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rv_decode_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic rv_decode_pkg::word_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic rv_decode_pkg::word_t enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic rv_decode_pkg::word_t enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // register 0 reads zero and only 4 index bits count with 16 registers
  function automatic rv_decode_pkg::word_t reg_value(logic [4:0] idx);
    return (idx[3:0] == 4'd0) ? 32'd0 : model[idx[3:0]];
  endfunction

  function automatic rv_decode_pkg::word_t op1_value(int sel, rv_decode_pkg::word_t pc,
                                                     rv_decode_pkg::word_t inst);
    case (sel)
      1: return pc;
      2: return reg_value(inst[19:15]);
      3: return reg_value(inst[24:20]);
      default: return 32'd0;
    endcase
  endfunction

  function automatic rv_decode_pkg::word_t op2_value(int sel, rv_decode_pkg::word_t imm,
                                                     rv_decode_pkg::word_t inst);
    case (sel)
      1: return 32'd4;
      2: return reg_value(inst[24:20]);
      3: return reg_value(inst[19:15]);
      default: return imm;
    endcase
  endfunction

  task automatic add_row(input string name, input rv_decode_pkg::word_t inst,
                         input rv_decode_pkg::alu_op_t alu, input int s1, input int s2,
                         input rv_decode_pkg::word_t imm, input logic [8:0] flags,
                         input bit jb_rs1);
    row_name.push_back(name);
    row_inst.push_back(inst);
    row_alu.push_back(alu);
    row_s1.push_back(s1);
    row_s2.push_back(s2);
    row_imm.push_back(imm);
    row_flags.push_back(flags);
    row_jb_rs1.push_back(jb_rs1);
  endtask

  task automatic load_table();
    add_row("addi", enc_i(-7, 3, 0, 5, 7'h13), 4'h0, 2, 0, 32'hffff_fff9, 9'b100000000, 0);
    add_row("srai", enc_i(12'h405, 2, 5, 6, 7'h13), 4'hd, 2, 0, 32'h405, 9'b100000000, 0);
    add_row("sub", enc_r(7'h20, 2, 1, 0, 7), 4'h8, 2, 2, 32'h0, 9'b100000000, 0);
    add_row("lw", enc_i(12, 4, 2, 8, 7'h03), 4'h0, 2, 0, 32'd12, 9'b110000000, 0);
    add_row("sw", enc_s(-4, 9, 10, 2), 4'h0, 2, 2, 32'hffff_fffc, 9'b001000000, 0);
    add_row("beq", enc_b(16, 2, 1, 0), 4'h8, 2, 2, 32'd16, 9'b000010000, 0);
    add_row("bge", enc_b(-8, 4, 3, 5), 4'ha, 3, 3, 32'hffff_fff8, 9'b000010000, 0);
    add_row("bgeu", enc_b(32, 6, 5, 7), 4'hb, 3, 3, 32'd32, 9'b000010000, 0);
    add_row("lui", {20'h12345, 5'd11, 7'h37}, 4'h0, 0, 0, 32'h1234_5000, 9'b100000000, 0);
    add_row("auipc", {20'hfffff, 5'd12, 7'h17}, 4'h0, 1, 0, 32'hffff_f000, 9'b100000000, 0);
    add_row("jal", enc_j(2048, 1), 4'h0, 1, 1, 32'h800, 9'b100100000, 0);
    add_row("jalr", enc_i(8, 13, 0, 1, 7'h67), 4'h0, 1, 1, 32'd8, 9'b100100000, 1);
    add_row("ebreak", 32'h0010_0073, 4'h0, 0, 0, 32'd1, 9'b000001010, 0);
    add_row("csrrw", enc_i(12'h300, 3, 1, 2, 7'h73), 4'h0, 2, 0, 32'h300, 9'b100001100, 0);
    add_row("illegal", 32'h1234_567f, 4'h0, 0, 0, 32'h0, 9'b000000001, 0);
  endtask

  // one writeback pulse that also clears the register in the scoreboard
  task automatic write_reg(input int r, input rv_decode_pkg::word_t v);
    @(posedge clk);
    wb_i <= '{valid: 1'b1, rd: r[4:0], data: v};
    if (r[3:0] != 0) begin
      model[r[3:0]] = v;
    end
    @(posedge clk);
    wb_i <= '0;
  endtask

  task automatic send_fetch(input rv_decode_pkg::word_t pc, input rv_decode_pkg::word_t inst);
    int  n;
    bit  ok;
    n = 0;
    ok = 0;
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_i       <= '{pc: pc, inst: inst};
    while (!ok && n < TIMEOUT) begin
      @(negedge clk);
      ok = fetch_ready_o;
      n++;
    end
    if (!ok) begin
      report_timeout("fetch ready");
    end
    // transfer edge
    @(posedge clk);
    fetch_valid_i <= 1'b0;
  endtask

  // samples at the falling edge and returns after the issue edge
  task automatic wait_issue(output rv_decode_pkg::issue_t pkt, output int cycles);
    bit ok;
    ok = 0;
    cycles = 0;
    while (!ok && cycles < TIMEOUT) begin
      @(negedge clk);
      if (issue_valid_o && issue_ready_i) begin
        pkt = issue_o;
        ok = 1;
      end else begin
        cycles++;
      end
    end
    if (!ok) begin
      report_timeout("issue valid");
    end
    @(posedge clk);
  endtask

  task automatic check_row(input int i, input rv_decode_pkg::word_t pc,
                           input rv_decode_pkg::issue_t pkt);
    rv_decode_pkg::word_t inst;
    rv_decode_pkg::word_t rs1v;
    inst = row_inst[i];
    rs1v = reg_value(inst[19:15]);
    check({row_name[i], " pc"}, pc, pkt.pc);
    check({row_name[i], " inst"}, inst, pkt.inst);
    check({row_name[i], " rd"}, inst[11:7], pkt.rd);
    check({row_name[i], " alu_op"}, row_alu[i], pkt.alu_op);
    check({row_name[i], " imm"}, row_imm[i], pkt.imm);
    check({row_name[i], " op1"}, op1_value(row_s1[i], pc, inst), pkt.op1);
    check({row_name[i], " op2"}, op2_value(row_s2[i], row_imm[i], inst), pkt.op2);
    check({row_name[i], " mem_addr"}, rs1v + row_imm[i], pkt.mem_addr);
    check({row_name[i], " jump_base"}, row_jb_rs1[i] ? rs1v : pc, pkt.jump_base);
    check({row_name[i], " flags"}, row_flags[i],
          {pkt.rd_wen, pkt.mem_ren, pkt.mem_wen, pkt.is_jump, pkt.is_branch,
           pkt.is_system, pkt.csr_wen, pkt.ebreak, pkt.illegal});
  endtask

  // add x5, rs1, x4 under the given bypass inputs
  task automatic bypass_case(input string name, input bit ev, input int erd, input bit wv,
                             input int wrd, input int rs1);
    rv_decode_pkg::word_t ed;
    rv_decode_pkg::word_t wd;
    rv_decode_pkg::word_t exp1;
    rv_decode_pkg::word_t exp2;
    ed = $urandom;
    wd = $urandom;
    // execute wins over writeback which wins over the register file
    exp1 = reg_value(rs1[4:0]);
    exp2 = reg_value(5'd4);
    if (rs1 != 0 && wv && wrd == rs1) exp1 = wd;
    if (rs1 != 0 && ev && erd == rs1) exp1 = ed;
    if (wv && wrd == 4) exp2 = wd;
    if (ev && erd == 4) exp2 = ed;
    send_fetch(32'h2000, enc_r(0, 4, rs1, 0, 5));
    // bypasses arrive on the transfer edge while the array still holds the old value
    exu_fwd_i <= '{valid: ev, rd: erd[4:0], data: ed};
    wb_i      <= '{valid: wv, rd: wrd[4:0], data: wd};
    if (wv && wrd[3:0] != 0) model[wrd[3:0]] = wd;
    wait_issue(got, waited);
    check({name, " op1"}, exp1, got.op1);
    check({name, " op2"}, exp2, got.op2);
    @(posedge clk);
    exu_fwd_i <= '0;
    wb_i <= '0;
    write_reg(5, $urandom);
  endtask

  // writer of rd then a stalled reader released by execute or writeback
  task automatic stall_case(input string name, input int rd, input bit by_wb);
    rv_decode_pkg::word_t fwd;
    fwd = $urandom;
    send_fetch(32'h3000, enc_i(5, 0, 0, rd, 7'h13));
    wait_issue(got, waited);
    send_fetch(32'h3004, enc_r(0, 1, rd, 0, 8));
    repeat (4) begin
      @(negedge clk);
      check({name, " stalled valid"}, 0, issue_valid_o);
    end
    @(posedge clk);
    if (by_wb) begin
      wb_i <= '{valid: 1'b1, rd: rd[4:0], data: fwd};
      model[rd[3:0]] = fwd;
    end else begin
      exu_fwd_i <= '{valid: 1'b1, rd: rd[4:0], data: fwd};
    end
    wait_issue(got, waited);
    check({name, " op1"}, fwd, got.op1);
    check({name, " op2"}, reg_value(5'd1), got.op2);
    @(posedge clk);
    exu_fwd_i <= '0;
    wb_i <= '0;
    // clears the writer and the reader destinations
    write_reg(rd, fwd);
    write_reg(8, $urandom);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_i = '0;
    issue_ready_i = 1'b1;
    exu_fwd_i = '0;
    wb_i = '0;
    model[0] = '0;
    void'($urandom(54));
    load_table();

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("reset issue_valid", 0, issue_valid_o);
    check("reset fetch_ready", 1, fetch_ready_o);

    for (int r = 1; r < 16; r++) begin
      write_reg(r, $urandom);
    end

    // decode rows with no hazard issue in the next cycle
    for (int i = 0; i < row_name.size(); i++) begin
      send_fetch(32'h1000 + 4 * i, row_inst[i]);
      wait_issue(got, waited);
      check({row_name[i], " latency"}, 0, waited);
      check_row(i, 32'h1000 + 4 * i, got);
      if (row_flags[i][8]) begin
        write_reg(row_inst[i][11:7], $urandom);
      end
    end

    bypass_case("exu only", 1, 3, 0, 0, 3);
    bypass_case("wb only", 0, 0, 1, 3, 3);
    bypass_case("exu over wb", 1, 3, 1, 3, 3);
    bypass_case("wb on rs2", 1, 6, 1, 4, 3);
    bypass_case("reg zero", 1, 0, 1, 0, 0);

    stall_case("stall exu", 7, 0);
    stall_case("stall wb", 9, 1);

    // random back-pressure while the table streams through
    fork
      for (int i = 0; i < row_name.size(); i++) begin
        send_fetch(32'h4000 + 4 * i, row_inst[i]);
      end
      for (int i = 0; i < row_name.size(); i++) begin
        bit seen;
        bit done;
        int n;
        seen = 0;
        done = 0;
        n = 0;
        while (!done && n < TIMEOUT) begin
          @(posedge clk);
          issue_ready_i <= ($urandom % 3 == 0);
          wb_i <= '0;
          @(negedge clk);
          if (issue_valid_o) begin
            if (!seen) begin
              saved = issue_o;
              seen = 1;
            end
            check({row_name[i], " held op1"}, saved.op1, issue_o.op1);
            check({row_name[i], " held op2"}, saved.op2, issue_o.op2);
            check({row_name[i], " held mem_addr"}, saved.mem_addr, issue_o.mem_addr);
            check({row_name[i], " held jump_base"}, saved.jump_base, issue_o.jump_base);
            if (issue_ready_i) begin
              check({row_name[i], " order inst"}, row_inst[i], issue_o.inst);
              check({row_name[i], " order pc"}, 32'h4000 + 4 * i, issue_o.pc);
              done = 1;
            end else begin
              check({row_name[i], " fetch_ready"}, 0, fetch_ready_o);
            end
          end
          n++;
        end
        if (!done) begin
          report_timeout("issue under back-pressure");
        end
        // issue edge then retire the destination one edge later
        @(posedge clk);
        issue_ready_i <= 1'b0;
        if (row_flags[i][8]) begin
          data = $urandom;
          wb_i <= '{valid: 1'b1, rd: row_inst[i][11:7], data: data};
          model[row_inst[i][10:7]] = data;
        end
      end
    join

    @(posedge clk);
    wb_i <= '0;
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
